//--- rtl/epdc_params.svh
`ifndef EPDC_PARAMS_SVH
`define EPDC_PARAMS_SVH

// Panel data format
`define EPDC_PIX_PER_COL 8
`define EPDC_LEVEL_W 4
`define EPDC_CODE_W 2
`define EPDC_COL_W (`EPDC_PIX_PER_COL * `EPDC_LEVEL_W)
`define EPDC_SD_W (`EPDC_PIX_PER_COL * `EPDC_CODE_W)

// Column, line and frame counters
`define EPDC_CNT_W 11
`define EPDC_FBYTES_W 24

// Wishbone register port
`define EPDC_WB_ADR_W 3
`define EPDC_WB_DAT_W 32

// Register word addresses
`define EPDC_REG_CTRL 3'd0
`define EPDC_REG_HSIZE 3'd1
`define EPDC_REG_VSIZE 3'd2
`define EPDC_REG_STATUS 3'd3
`define EPDC_REG_FCOUNT 3'd4

`endif

//--- rtl/epdc_pkg.sv
`include "epdc_params.svh"

package epdc_pkg;

    // Frame scan FSM states
    typedef enum logic [1:0] {
        SCAN_IDLE        = 2'd0,
        SCAN_FRAME_START = 2'd1,
        SCAN_LINE_DATA   = 2'd2,
        SCAN_LINE_END    = 2'd3
    } scan_state_e;

    // Per pixel source driver code
    typedef enum logic [`EPDC_CODE_W-1:0] {
        DRIVE_NONE    = 2'd0,
        DRIVE_DARKEN  = 2'd1,
        DRIVE_LIGHTEN = 2'd2
    } drive_e;

    // Panel geometry in columns per line and lines per frame
    typedef struct packed {
        logic [`EPDC_CNT_W-1:0] h_size;
        logic [`EPDC_CNT_W-1:0] v_size;
    } panel_cfg_t;

    // Gate and source driver strobes
    typedef struct packed {
        logic gdoe;
        logic gdclk;
        logic gdsp;
        logic sdclk;
        logic sdle;
        logic sdoe;
        logic sdce0;
    } epd_bus_t;

endpackage

//--- rtl/epdc_csr.sv
`timescale 1ns/1ps
`include "epdc_params.svh"

module epdc_csr (
    input  logic                         clk_epdc,
    input  logic                         reset,
    // Wishbone classic slave
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [`EPDC_WB_ADR_W-1:0]    wb_adr,
    input  logic [`EPDC_WB_DAT_W-1:0]    wb_dat_w,
    output logic [`EPDC_WB_DAT_W-1:0]    wb_dat_r,
    output logic                         wb_ack,
    // System status, already synchronized
    input  logic                         sys_ready,
    input  logic                         mig_error,
    input  logic                         mif_error,
    // Scan generator
    input  epdc_pkg::scan_state_e        scan_state,
    input  logic                         frame_done,
    output logic                         start,
    output logic                         global_en,
    output epdc_pkg::panel_cfg_t         panel_cfg,
    output logic [`EPDC_FBYTES_W-1:0]    frame_bytes
);

    logic                      wb_req;
    logic                      wb_wr;
    logic                      busy;
    logic                      start_ok;
    logic [`EPDC_CNT_W-1:0]    fcount;
    logic [`EPDC_WB_DAT_W-1:0] rd_data;

    // New request only while no ack is outstanding
    assign wb_req = wb_cyc && wb_stb && !wb_ack;
    assign wb_wr = wb_req && wb_we;

    assign busy = (scan_state != epdc_pkg::SCAN_IDLE);
    assign start_ok = sys_ready && !mig_error && !mif_error;

    always_ff @(posedge clk_epdc) begin
        if (reset) begin
            wb_ack <= 1'b0;
            global_en <= 1'b0;
            start <= 1'b0;
            panel_cfg <= '0;
        end else begin
            wb_ack <= wb_req;
            start <= 1'b0;
            if (wb_wr) begin
                case (wb_adr)
                    `EPDC_REG_CTRL: begin
                        global_en <= wb_dat_w[0];
                        // Start is qualified by the enable value written with it
                        start <= wb_dat_w[1] && wb_dat_w[0] && start_ok;
                    end
                    `EPDC_REG_HSIZE: panel_cfg.h_size <= wb_dat_w[`EPDC_CNT_W-1:0];
                    `EPDC_REG_VSIZE: panel_cfg.v_size <= wb_dat_w[`EPDC_CNT_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Frames completed since reset
    always_ff @(posedge clk_epdc) begin
        if (reset) begin
            fcount <= '0;
        end else if (frame_done) begin
            fcount <= fcount + 1'b1;
        end
    end

    always_comb begin
        rd_data = '0;
        case (wb_adr)
            `EPDC_REG_CTRL:   rd_data[0] = global_en;
            `EPDC_REG_HSIZE:  rd_data[`EPDC_CNT_W-1:0] = panel_cfg.h_size;
            `EPDC_REG_VSIZE:  rd_data[`EPDC_CNT_W-1:0] = panel_cfg.v_size;
            `EPDC_REG_STATUS: rd_data[3:0] = {mif_error, mig_error, sys_ready, busy};
            `EPDC_REG_FCOUNT: rd_data[`EPDC_CNT_W-1:0] = fcount;
            default:          rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_epdc) begin
        if (wb_req) begin
            wb_dat_r <= rd_data;
        end
    end

    // Four bytes per column slot, needed by the memory side before each frame
    always_ff @(posedge clk_epdc) begin
        frame_bytes <= `EPDC_FBYTES_W'(panel_cfg.h_size) *
                       `EPDC_FBYTES_W'(panel_cfg.v_size) * `EPDC_FBYTES_W'(4);
    end

    // Each classic cycle gets exactly one ack beat
    ack_single_beat: assert property (
        @(posedge clk_epdc) disable iff (reset)
        wb_ack |=> !wb_ack
    );

endmodule

//--- rtl/epdc_scan.sv
`timescale 1ns/1ps
`include "epdc_params.svh"

module epdc_scan (
    input  logic                    clk_epdc,
    input  logic                    reset,
    input  logic                    start,
    input  epdc_pkg::panel_cfg_t    panel_cfg,
    // Column handoff with the waveform stage
    input  logic                    col_valid,
    output logic                    col_take,
    // Panel strobes and frame status
    output epdc_pkg::epd_bus_t      epd_bus,
    output logic                    b_trigger,
    output logic                    frame_done,
    output epdc_pkg::scan_state_e   scan_state
);

    epdc_pkg::scan_state_e  state_q;
    epdc_pkg::panel_cfg_t   cfg_q;
    logic [`EPDC_CNT_W-1:0] col_cnt;
    logic [`EPDC_CNT_W-1:0] line_cnt;
    logic                   end_phase;
    logic                   last_col;
    logic                   last_line;
    logic                   in_frame;

    assign scan_state = state_q;

    assign last_col = (col_cnt == cfg_q.h_size - 1'b1);
    assign last_line = (line_cnt == cfg_q.v_size - 1'b1);
    assign in_frame = (state_q != epdc_pkg::SCAN_IDLE);

    // Shift a column out whenever one is waiting during line data
    assign col_take = (state_q == epdc_pkg::SCAN_LINE_DATA) && col_valid;

    assign b_trigger = (state_q == epdc_pkg::SCAN_FRAME_START);

    // Second line end cycle of the last line closes the frame
    assign frame_done = (state_q == epdc_pkg::SCAN_LINE_END) && end_phase && last_line;

    // Geometry is held steady for the whole frame
    always_ff @(posedge clk_epdc) begin
        if ((state_q == epdc_pkg::SCAN_IDLE) && start) begin
            cfg_q <= panel_cfg;
        end
    end

    always_ff @(posedge clk_epdc) begin
        if (reset) begin
            state_q <= epdc_pkg::SCAN_IDLE;
            col_cnt <= '0;
            line_cnt <= '0;
            end_phase <= 1'b0;
        end else begin
            case (state_q)
                epdc_pkg::SCAN_IDLE: begin
                    col_cnt <= '0;
                    line_cnt <= '0;
                    end_phase <= 1'b0;
                    if (start) begin
                        state_q <= epdc_pkg::SCAN_FRAME_START;
                    end
                end
                epdc_pkg::SCAN_FRAME_START: begin
                    state_q <= epdc_pkg::SCAN_LINE_DATA;
                end
                epdc_pkg::SCAN_LINE_DATA: begin
                    // Line stretches while no column is ready
                    if (col_take) begin
                        if (last_col) begin
                            col_cnt <= '0;
                            end_phase <= 1'b0;
                            state_q <= epdc_pkg::SCAN_LINE_END;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                        end
                    end
                end
                epdc_pkg::SCAN_LINE_END: begin
                    if (!end_phase) begin
                        end_phase <= 1'b1;
                    end else begin
                        end_phase <= 1'b0;
                        if (last_line) begin
                            state_q <= epdc_pkg::SCAN_IDLE;
                        end else begin
                            line_cnt <= line_cnt + 1'b1;
                            state_q <= epdc_pkg::SCAN_LINE_DATA;
                        end
                    end
                end
                default: begin
                    state_q <= epdc_pkg::SCAN_IDLE;
                end
            endcase
        end
    end

    // Strobes decode straight from the FSM so sdclk lines up with the taken column
    always_comb begin
        epd_bus = '0;
        epd_bus.gdsp = (state_q == epdc_pkg::SCAN_FRAME_START);
        epd_bus.sdclk = col_take;
        // Latch the source row, then advance the gate
        epd_bus.sdle = (state_q == epdc_pkg::SCAN_LINE_END) && !end_phase;
        epd_bus.gdclk = (state_q == epdc_pkg::SCAN_LINE_END) && end_phase;
        epd_bus.gdoe = in_frame;
        epd_bus.sdoe = in_frame;
        epd_bus.sdce0 = in_frame;
    end

    state_legal: assert property (
        @(posedge clk_epdc) disable iff (reset)
        state_q inside {epdc_pkg::SCAN_IDLE, epdc_pkg::SCAN_FRAME_START,
                        epdc_pkg::SCAN_LINE_DATA, epdc_pkg::SCAN_LINE_END}
    );

    // A source clock never runs past the configured line length
    sdclk_has_column: assert property (
        @(posedge clk_epdc) disable iff (reset)
        epd_bus.sdclk |-> col_take && (col_cnt < cfg_q.h_size)
    );

    // Latch enable is followed by a gate clock, never overlapping it
    sdle_then_gdclk: assert property (
        @(posedge clk_epdc) disable iff (reset)
        epd_bus.sdle |-> !epd_bus.gdclk ##1 (epd_bus.gdclk && !epd_bus.sdle)
    );

endmodule

//--- rtl/epdc_waveform.sv
`timescale 1ns/1ps
`include "epdc_params.svh"

module epdc_waveform (
    input  logic                    clk_epdc,
    input  logic                    reset,
    // Target levels from video input
    input  logic [`EPDC_COL_W-1:0]  vin_pixel,
    input  logic                    vin_valid,
    output logic                    vin_ready,
    // Stored levels from the framebuffer
    input  logic [`EPDC_COL_W-1:0]  bi_pixel,
    input  logic                    bi_valid,
    output logic                    bi_ready,
    // Column handoff with the scan generator
    output logic                    col_valid,
    input  logic                    col_take,
    output logic [`EPDC_SD_W-1:0]   sd_codes,
    // Write-back toward the framebuffer
    output logic [`EPDC_COL_W-1:0]  bo_pixel,
    output logic                    bo_valid
);

    logic                   out_valid;
    logic                   in_fire;
    logic [`EPDC_SD_W-1:0]  sd_next;
    logic [`EPDC_SD_W-1:0]  sd_q;
    logic [`EPDC_COL_W-1:0] lvl_next;
    logic [`EPDC_COL_W-1:0] lvl_q;

    // Both streams move together, and only into a free or emptying register
    assign vin_ready = vin_valid && bi_valid && (!out_valid || col_take);
    assign bi_ready = vin_ready;
    assign in_fire = vin_valid && vin_ready && bi_valid && bi_ready;

    // One level step per frame toward the target
    always_comb begin : step_calc
        logic [`EPDC_LEVEL_W-1:0] tgt;
        logic [`EPDC_LEVEL_W-1:0] cur;
        logic [`EPDC_LEVEL_W-1:0] nxt;
        epdc_pkg::drive_e         code;
        sd_next = '0;
        lvl_next = '0;
        for (int i = 0; i < `EPDC_PIX_PER_COL; i++) begin
            tgt = vin_pixel[i*`EPDC_LEVEL_W +: `EPDC_LEVEL_W];
            cur = bi_pixel[i*`EPDC_LEVEL_W +: `EPDC_LEVEL_W];
            if (tgt > cur) begin
                code = epdc_pkg::DRIVE_LIGHTEN;
                nxt = cur + 1'b1;
            end else if (tgt < cur) begin
                code = epdc_pkg::DRIVE_DARKEN;
                nxt = cur - 1'b1;
            end else begin
                code = epdc_pkg::DRIVE_NONE;
                nxt = cur;
            end
            sd_next[i*`EPDC_CODE_W +: `EPDC_CODE_W] = code;
            lvl_next[i*`EPDC_LEVEL_W +: `EPDC_LEVEL_W] = nxt;
        end
    end

    always_ff @(posedge clk_epdc) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_fire) begin
            out_valid <= 1'b1;
        end else if (col_take) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_epdc) begin
        if (in_fire) begin
            sd_q <= sd_next;
            lvl_q <= lvl_next;
        end
    end

    assign col_valid = out_valid;
    assign sd_codes = sd_q;

    // Write-back happens as the column reaches the panel
    assign bo_pixel = lvl_q;
    assign bo_valid = col_take;

    take_needs_column: assert property (
        @(posedge clk_epdc) disable iff (reset)
        col_take |-> col_valid
    );

endmodule

//--- rtl/epdc_top.sv
`timescale 1ns/1ps
`include "epdc_params.svh"

module epdc_top (
    input  logic                        clk_epdc,
    input  logic                        reset,
    // Wishbone register port
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [`EPDC_WB_ADR_W-1:0]   wb_adr,
    input  logic [`EPDC_WB_DAT_W-1:0]   wb_dat_w,
    output logic [`EPDC_WB_DAT_W-1:0]   wb_dat_r,
    output logic                        wb_ack,
    // System status
    input  logic                        sys_ready,
    input  logic                        mig_error,
    input  logic                        mif_error,
    // Video and framebuffer streams
    input  logic [`EPDC_COL_W-1:0]      vin_pixel,
    input  logic                        vin_valid,
    output logic                        vin_ready,
    input  logic [`EPDC_COL_W-1:0]      bi_pixel,
    input  logic                        bi_valid,
    output logic                        bi_ready,
    output logic [`EPDC_COL_W-1:0]      bo_pixel,
    output logic                        bo_valid,
    // Panel pins
    output logic                        epd_gdoe,
    output logic                        epd_gdclk,
    output logic                        epd_gdsp,
    output logic                        epd_sdclk,
    output logic                        epd_sdle,
    output logic                        epd_sdoe,
    output logic                        epd_sdce0,
    output logic [`EPDC_SD_W-1:0]       epd_sd,
    // Frame control toward the memory side
    output logic                        b_trigger,
    output logic                        global_en,
    output logic [`EPDC_FBYTES_W-1:0]   frame_bytes
);

    logic                   start;
    logic                   frame_done;
    logic                   col_valid;
    logic                   col_take;
    epdc_pkg::scan_state_e  scan_state;
    epdc_pkg::panel_cfg_t   panel_cfg;
    epdc_pkg::epd_bus_t     epd_bus;

    epdc_csr epdc_csr_inst (
        .clk_epdc    (clk_epdc),
        .reset       (reset),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .sys_ready   (sys_ready),
        .mig_error   (mig_error),
        .mif_error   (mif_error),
        .scan_state  (scan_state),
        .frame_done  (frame_done),
        .start       (start),
        .global_en   (global_en),
        .panel_cfg   (panel_cfg),
        .frame_bytes (frame_bytes)
    );

    epdc_scan epdc_scan_inst (
        .clk_epdc   (clk_epdc),
        .reset      (reset),
        .start      (start),
        .panel_cfg  (panel_cfg),
        .col_valid  (col_valid),
        .col_take   (col_take),
        .epd_bus    (epd_bus),
        .b_trigger  (b_trigger),
        .frame_done (frame_done),
        .scan_state (scan_state)
    );

    epdc_waveform epdc_waveform_inst (
        .clk_epdc  (clk_epdc),
        .reset     (reset),
        .vin_pixel (vin_pixel),
        .vin_valid (vin_valid),
        .vin_ready (vin_ready),
        .bi_pixel  (bi_pixel),
        .bi_valid  (bi_valid),
        .bi_ready  (bi_ready),
        .col_valid (col_valid),
        .col_take  (col_take),
        .sd_codes  (epd_sd),
        .bo_pixel  (bo_pixel),
        .bo_valid  (bo_valid)
    );

    // Panel strobes onto the pins
    assign epd_gdoe = epd_bus.gdoe;
    assign epd_gdclk = epd_bus.gdclk;
    assign epd_gdsp = epd_bus.gdsp;
    assign epd_sdclk = epd_bus.sdclk;
    assign epd_sdle = epd_bus.sdle;
    assign epd_sdoe = epd_bus.sdoe;
    assign epd_sdce0 = epd_bus.sdce0;

endmodule

//--- verif/epdc_tb.sv
`timescale 1ns/1ps
`include "epdc_params.svh"

module epdc_tb;

    localparam int NUM_FRAMES = 8;
    // Largest panel drawn is 6 columns by 4 lines
    localparam int MAX_COLS = NUM_FRAMES * 6 * 4;
    localparam int WATCHDOG_CYCLES = MAX_COLS * 200 + 2000;

    logic                       clk_epdc;
    logic                       reset;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    logic [`EPDC_WB_ADR_W-1:0]  wb_adr;
    logic [`EPDC_WB_DAT_W-1:0]  wb_dat_w;
    logic [`EPDC_WB_DAT_W-1:0]  wb_dat_r;
    logic                       wb_ack;
    logic                       sys_ready;
    logic                       mig_error;
    logic                       mif_error;
    logic [`EPDC_COL_W-1:0]     vin_pixel;
    logic                       vin_valid;
    logic                       vin_ready;
    logic [`EPDC_COL_W-1:0]     bi_pixel;
    logic                       bi_valid;
    logic                       bi_ready;
    logic [`EPDC_COL_W-1:0]     bo_pixel;
    logic                       bo_valid;
    logic                       epd_gdoe;
    logic                       epd_gdclk;
    logic                       epd_gdsp;
    logic                       epd_sdclk;
    logic                       epd_sdle;
    logic                       epd_sdoe;
    logic                       epd_sdce0;
    logic [`EPDC_SD_W-1:0]      epd_sd;
    logic                       b_trigger;
    logic                       global_en;
    logic [`EPDC_FBYTES_W-1:0]  frame_bytes;

    // Reference model state
    logic [`EPDC_COL_W-1:0]     tgt_q[$];
    logic [`EPDC_COL_W-1:0]     cur_q[$];
    logic [`EPDC_COL_W-1:0]     mon_tgt;
    logic [`EPDC_COL_W-1:0]     mon_cur;
    int                         exp_h;
    int                         exp_v;
    int                         exp_fcount;
    int                         sd_in_line;
    int                         gd_in_frame;
    int                         trig_count;
    int                         frames_done;
    int                         error_count;
    logic                       prev_sdle;
    logic                       prev_sdoe;
    logic                       prev_trig;
    logic                       frame_open;

    epdc_top epdc_top_inst (
        .clk_epdc(clk_epdc), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .sys_ready(sys_ready), .mig_error(mig_error), .mif_error(mif_error),
        .vin_pixel(vin_pixel), .vin_valid(vin_valid), .vin_ready(vin_ready),
        .bi_pixel(bi_pixel), .bi_valid(bi_valid), .bi_ready(bi_ready),
        .bo_pixel(bo_pixel), .bo_valid(bo_valid),
        .epd_gdoe(epd_gdoe), .epd_gdclk(epd_gdclk), .epd_gdsp(epd_gdsp),
        .epd_sdclk(epd_sdclk), .epd_sdle(epd_sdle), .epd_sdoe(epd_sdoe),
        .epd_sdce0(epd_sdce0), .epd_sd(epd_sd),
        .b_trigger(b_trigger), .global_en(global_en), .frame_bytes(frame_bytes)
    );

    initial begin
        clk_epdc = 1'b0;
        forever #10 clk_epdc = ~clk_epdc;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL time=%0t signal=%s got=0x%0h expected=0x%0h",
                     $time, name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("%s at time %0t", msg, $time);
        $display("Errors found");
        $fatal(1);
    endtask

    // Expected drive codes, 2 for lighten, 1 for darken
    function automatic logic [`EPDC_SD_W-1:0] step_codes(input logic [`EPDC_COL_W-1:0] tgt,
                                                        input logic [`EPDC_COL_W-1:0] cur);
        logic [`EPDC_SD_W-1:0] codes;
        int t;
        int c;
        codes = '0;
        for (int p = 0; p < `EPDC_PIX_PER_COL; p++) begin
            t = tgt[p*`EPDC_LEVEL_W +: `EPDC_LEVEL_W];
            c = cur[p*`EPDC_LEVEL_W +: `EPDC_LEVEL_W];
            if (t > c) begin
                codes[p*2 +: 2] = 2'd2;
            end else if (t < c) begin
                codes[p*2 +: 2] = 2'd1;
            end
        end
        return codes;
    endfunction

    // Stored level moves one step toward the target
    function automatic logic [`EPDC_COL_W-1:0] step_levels(input logic [`EPDC_COL_W-1:0] tgt,
                                                          input logic [`EPDC_COL_W-1:0] cur);
        logic [`EPDC_COL_W-1:0] lvls;
        int t;
        int c;
        lvls = '0;
        for (int p = 0; p < `EPDC_PIX_PER_COL; p++) begin
            t = tgt[p*`EPDC_LEVEL_W +: `EPDC_LEVEL_W];
            c = cur[p*`EPDC_LEVEL_W +: `EPDC_LEVEL_W];
            c = c + ((t > c) ? 1 : 0) - ((t < c) ? 1 : 0);
            lvls[p*`EPDC_LEVEL_W +: `EPDC_LEVEL_W] = c[`EPDC_LEVEL_W-1:0];
        end
        return lvls;
    endfunction

    // One classic cycle, ack expected on the edge after the request
    task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        @(negedge clk_epdc);
        check_value("wb_ack", wb_ack, 1'b0);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdata;
        @(negedge clk_epdc);
        check_value("wb_ack", wb_ack, 1'b1);
        rdata = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] wdata);
        logic [31:0] unused_data;
        wb_access(1'b1, adr, wdata, unused_data);
    endtask

    task automatic wb_read_check(input logic [2:0] adr, input logic [31:0] exp,
                                 input string name);
        logic [31:0] data;
        wb_access(1'b0, adr, '0, data);
        check_value(name, data, exp);
    endtask

    // Random levels, with some pixels already at their target
    task automatic make_column(output logic [`EPDC_COL_W-1:0] tgt,
                               output logic [`EPDC_COL_W-1:0] cur);
        tgt = $urandom;
        cur = $urandom;
        for (int p = 0; p < `EPDC_PIX_PER_COL; p++) begin
            if ($urandom % 4 == 0) begin
                tgt[p*`EPDC_LEVEL_W +: `EPDC_LEVEL_W] = cur[p*`EPDC_LEVEL_W +: `EPDC_LEVEL_W];
            end
        end
    endtask

    // Far side of the video and framebuffer streams, with random valid gaps
    task automatic drive_columns(input int count);
        logic [`EPDC_COL_W-1:0] tgt;
        logic [`EPDC_COL_W-1:0] cur;
        logic                   took;
        logic                   exp_ready;
        for (int n = 0; n < count; n++) begin
            make_column(tgt, cur);
            took = 1'b0;
            while (!took) begin
                @(negedge clk_epdc);
                vin_pixel = tgt;
                bi_pixel = cur;
                vin_valid = ($urandom % 4) != 0;
                bi_valid = ($urandom % 4) != 0;
                @(posedge clk_epdc);
                // Output register is free when no column waits, or it leaves now
                exp_ready = vin_valid && bi_valid && ((tgt_q.size() == 0) || epd_sdclk);
                if ((vin_ready || bi_ready) && !(vin_valid && bi_valid)) begin
                    report_error("Input stream consumed while a valid was low");
                end
                check_value("vin_ready", vin_ready, exp_ready);
                check_value("bi_ready", bi_ready, exp_ready);
                if (vin_valid && vin_ready) begin
                    took = 1'b1;
                    tgt_q.push_back(tgt);
                    cur_q.push_back(cur);
                end
            end
        end
        @(negedge clk_epdc);
        vin_valid = 1'b0;
        bi_valid = 1'b0;
    endtask

    task automatic start_blocked(input logic en, input logic rdy, input logic mig,
                                 input logic mif);
        int trig_before;
        trig_before = trig_count;
        @(negedge clk_epdc);
        sys_ready = rdy;
        mig_error = mig;
        mif_error = mif;
        wb_write(`EPDC_REG_CTRL, {30'd0, 1'b1, en});
        check_value("global_en", global_en, en);
        // Accepted start would trigger two edges after the write
        repeat (4) @(posedge clk_epdc);
        check_value("b_trigger pulses", trig_count, trig_before);
        wb_read_check(`EPDC_REG_STATUS, {28'd0, mif, mig, rdy, 1'b0}, "STATUS");
    endtask

    task automatic run_frame(input int h, input int v);
        int trig_before;
        int done_before;
        wb_write(`EPDC_REG_HSIZE, h);
        wb_write(`EPDC_REG_VSIZE, v);
        wb_read_check(`EPDC_REG_HSIZE, h, "HSIZE");
        wb_read_check(`EPDC_REG_VSIZE, v, "VSIZE");
        check_value("frame_bytes", frame_bytes, h * v * 4);
        exp_h = h;
        exp_v = v;
        trig_before = trig_count;
        done_before = frames_done;
        fork
            drive_columns(h * v);
            begin
                wb_write(`EPDC_REG_CTRL, 32'h3);
                check_value("global_en", global_en, 1'b1);
                wait (frames_done == done_before + 1);
            end
        join
        exp_fcount++;
        check_value("b_trigger pulses", trig_count, trig_before + 1);
        check_value("columns left", tgt_q.size(), 0);
        wb_read_check(`EPDC_REG_FCOUNT, exp_fcount, "FCOUNT");
        wb_read_check(`EPDC_REG_STATUS, 32'h2, "STATUS");
    endtask

    // Panel side monitor, sampled before the edge updates anything
    always @(posedge clk_epdc) begin
        if (!reset) begin
            check_value("bo_valid", bo_valid, epd_sdclk);
            check_value("epd_gdsp", epd_gdsp, b_trigger);
            // Output enables span the frame start cycle through the last gdclk
            check_value("epd_sdoe", epd_sdoe, b_trigger || frame_open);
            check_value("epd_gdoe", epd_gdoe, b_trigger || frame_open);
            check_value("epd_sdce0", epd_sdce0, b_trigger || frame_open);
            if (epd_sdclk) begin
                if (tgt_q.size() == 0) begin
                    report_error("Source clock seen with no column sent");
                end else begin
                    mon_tgt = tgt_q.pop_front();
                    mon_cur = cur_q.pop_front();
                    check_value("epd_sd", epd_sd, step_codes(mon_tgt, mon_cur));
                    check_value("bo_pixel", bo_pixel, step_levels(mon_tgt, mon_cur));
                    sd_in_line++;
                end
            end
            if (epd_sdle) begin
                check_value("sdclk pulses per line", sd_in_line, exp_h);
            end
            if (epd_gdclk) begin
                check_value("sdle before gdclk", prev_sdle, 1'b1);
                sd_in_line = 0;
                gd_in_frame++;
                if (gd_in_frame == exp_v) begin
                    frame_open = 1'b0;
                end
            end
            if (b_trigger) begin
                check_value("b_trigger width", prev_trig, 1'b0);
                trig_count++;
                sd_in_line = 0;
                gd_in_frame = 0;
                frame_open = 1'b1;
            end
            if (prev_sdoe && !epd_sdoe) begin
                check_value("gdclk pulses per frame", gd_in_frame, exp_v);
                frames_done++;
            end
            prev_sdle = epd_sdle;
            prev_sdoe = epd_sdoe;
            prev_trig = b_trigger;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_epdc);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $fatal(1);
    end

    initial begin
        int unused_rand;
        int h;
        int v;
        unused_rand = $urandom(95);
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        sys_ready = 1'b0;
        mig_error = 1'b0;
        mif_error = 1'b0;
        vin_pixel = '0;
        vin_valid = 1'b0;
        bi_pixel = '0;
        bi_valid = 1'b0;
        exp_h = 0;
        exp_v = 0;
        exp_fcount = 0;
        sd_in_line = 0;
        gd_in_frame = 0;
        trig_count = 0;
        frames_done = 0;
        error_count = 0;
        prev_sdle = 1'b0;
        prev_sdoe = 1'b0;
        prev_trig = 1'b0;
        frame_open = 1'b0;
        repeat (3) @(posedge clk_epdc);
        @(negedge clk_epdc);
        reset = 1'b0;

        check_value("panel strobes", {epd_gdoe, epd_gdclk, epd_gdsp, epd_sdclk,
                                      epd_sdle, epd_sdoe, epd_sdce0}, '0);
        check_value("b_trigger", b_trigger, 1'b0);
        check_value("bo_valid", bo_valid, 1'b0);
        check_value("vin_ready", vin_ready, 1'b0);
        check_value("bi_ready", bi_ready, 1'b0);
        check_value("wb_ack", wb_ack, 1'b0);

        // Register map with full range geometry
        h = $urandom % 2048;
        v = $urandom % 2048;
        wb_write(`EPDC_REG_HSIZE, h);
        wb_write(`EPDC_REG_VSIZE, v);
        wb_read_check(`EPDC_REG_HSIZE, h, "HSIZE");
        wb_read_check(`EPDC_REG_VSIZE, v, "VSIZE");
        check_value("frame_bytes", frame_bytes, h * v * 4);
        for (int a = 5; a < 8; a++) begin
            wb_read_check(3'(a), 32'h0, "unmapped register");
        end
        wb_read_check(`EPDC_REG_CTRL, 32'h0, "CTRL");
        wb_read_check(`EPDC_REG_FCOUNT, 32'h0, "FCOUNT");

        start_blocked(1'b0, 1'b1, 1'b0, 1'b0);
        start_blocked(1'b1, 1'b0, 1'b0, 1'b0);
        start_blocked(1'b1, 1'b1, 1'b1, 1'b0);
        start_blocked(1'b1, 1'b1, 1'b0, 1'b1);

        @(negedge clk_epdc);
        sys_ready = 1'b1;
        mig_error = 1'b0;
        mif_error = 1'b0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            h = 1 + $urandom % 6;
            v = 1 + $urandom % 4;
            run_frame(h, v);
        end

        if (error_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1);
        end
    end

endmodule

//--- filelist.f
+incdir+rtl
rtl/epdc_pkg.sv
rtl/epdc_csr.sv
rtl/epdc_scan.sv
rtl/epdc_waveform.sv
rtl/epdc_top.sv
verif/epdc_tb.sv

//--- Makefile
TOP = epdc_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f filelist.f -o sim_epdc
	./obj_dir/sim_epdc | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
